// ==== all.f ====
+incdir+include
design/fetch_pkg.sv
design/icache.sv
design/branch_predictor.sv
design/fetch_ctrl.sv
design/fetch_top.sv
dv/tb_clock.sv
dv/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the fetch stage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module fetch_tb -o fetch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
run_status=$?

cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

exit 0

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int NUM_STEPS = 22;
  localparam int TIMEOUT_CYCLES = NUM_STEPS * 40;
  localparam int PROG_WORDS = 16;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic                   spec;
    redirect_t              redirect;
    logic                   flush;
  } step_t;

  logic clk;
  logic rst;
  mem_req_t   mem_req_o;
  logic       mem_req_valid_o;
  logic       mem_req_ready_i;
  mem_rsp_t   mem_rsp_i;
  redirect_t  redirect_i;
  fetch_out_t fetch_o;
  logic       fetch_valid_o;
  logic       fetch_ready_i;
  logic       flush_o;

  integer seed;
  int     error_count = 0;
  int     cycle_count = 0;
  int     n_steps = 0;
  int     row_reqs = 0;
  logic [`FETCH_XLEN-1:0] cur_pc;
  logic [`FETCH_XLEN-1:0] prog [PROG_WORDS];
  step_t  steps [NUM_STEPS];
  logic       was_stalled = 1'b0;
  fetch_out_t held_out;

  // reference model state
  logic [`FETCH_XLEN-1:0] m_pc;
  logic                   m_hold;
  logic                   m_spec;
  logic [`FETCH_XLEN-1:0] m_spec_target;
  logic                   m_pred_v;
  logic [`FETCH_XLEN-1:0] m_pred_t;
  logic                   m_line_v [4];
  logic [26:0]            m_line_tag [4];

  tb_clock u_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  fetch_top uut (
    .clk             (clk),
    .rst             (rst),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .redirect_i      (redirect_i),
    .fetch_o         (fetch_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_ready_i   (fetch_ready_i),
    .flush_o         (flush_o)
  );

  // ====================
  // checks
  // ====================

  task automatic stop_with_failure();
    error_count++;
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_fetch(input string what, input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got pc=%h inst=%h spec=%b, expected pc=%h inst=%h spec=%b",
               $time, what, got.pc, got.inst, got.spec, exp.pc, exp.inst, exp.spec);
      stop_with_failure();
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: mem_req_o.addr got %h, expected %h",
               $time, got.addr, exp.addr);
      stop_with_failure();
    end
  endtask

  task automatic check_flush(input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: flush_o got %b, expected %b", $time, got, exp);
      stop_with_failure();
    end
  endtask

  // a stalled output must come back unchanged in the next cycle
  task automatic watch_cycle(input logic exp_flush);
    check_flush(flush_o, exp_flush);
    if (was_stalled) begin
      if (fetch_valid_o !== 1'b1) begin
        $display("fetch_valid_o dropped at %0t while decode was stalling", $time);
        stop_with_failure();
      end
      check_fetch("fetch_o under stall", fetch_o, held_out);
    end
    was_stalled = fetch_valid_o && !fetch_ready_i;
    held_out = fetch_o;
  endtask

  // ====================
  // program and model helpers
  // ====================

  function automatic logic [`FETCH_XLEN-1:0] fill_word(input logic [`FETCH_XLEN-1:0] a);
    return {a[31:7] ^ a[24:0], 7'h13};
  endfunction

  function automatic logic [`FETCH_XLEN-1:0] prog_word(input logic [`FETCH_XLEN-1:0] addr);
    logic [`FETCH_XLEN-1:0] ofs;
    ofs = addr - `FETCH_PC_INIT;
    return prog[ofs[5:2]];
  endfunction

  function automatic inst_class_e classify(input logic [`FETCH_XLEN-1:0] inst);
    case (inst[6:0])
      `FETCH_OP_JAL, `FETCH_OP_JALR, `FETCH_OP_BRANCH, `FETCH_OP_SYSTEM: return CLS_CTRL;
      `FETCH_OP_LOAD: return CLS_LOAD;
      default: return CLS_SEQ;
    endcase
  endfunction

  function automatic logic line_resident(input logic [`FETCH_XLEN-1:0] pc);
    return m_line_v[pc[4:3]] && (m_line_tag[pc[4:3]] == pc[31:5]);
  endfunction

  task automatic add_row(input logic [31:0] pc_ofs, input logic spec, input logic rd_valid,
                         input logic rd_taken, input logic [31:0] npc_ofs, input logic flush);
    steps[n_steps].pc = `FETCH_PC_INIT + pc_ofs;
    steps[n_steps].spec = spec;
    steps[n_steps].redirect.valid = rd_valid;
    steps[n_steps].redirect.taken = rd_taken;
    steps[n_steps].redirect.npc = `FETCH_PC_INIT + npc_ofs;
    steps[n_steps].flush = flush;
    n_steps++;
  endtask

  // ====================
  // memory model
  // ====================

  initial begin : memory_model
    logic [`FETCH_XLEN-1:0] rsp_addr;
    int       rsp_wait;
    integer   rnd;
    mem_req_t exp_req;
    mem_req_ready_i = 1'b0;
    mem_rsp_i = '0;
    rsp_addr = '0;
    rsp_wait = 0;
    forever begin
      @(negedge clk);
      mem_rsp_i = '0;
      if (rsp_wait > 0) begin
        rsp_wait = rsp_wait - 1;
        if (rsp_wait == 0) begin
          mem_rsp_i.valid = 1'b1;
          mem_rsp_i.data = prog_word(rsp_addr);
        end
      end
      mem_req_ready_i = ($random(seed) & 3) != 0;
      #1;
      if (mem_req_valid_o && mem_req_ready_i) begin
        // even word of the line first, then the odd word
        exp_req.addr = {cur_pc[31:3], 3'b000} + 32'(row_reqs * 4);
        check_req(mem_req_o, exp_req);
        row_reqs++;
        rsp_addr = mem_req_o.addr;
        rnd = $random(seed);
        rsp_wait = 1 + ((rnd & 32'h7fff_ffff) % 3);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run took more than %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // ====================
  // stimulus
  // ====================

  initial begin : main
    step_t      row;
    fetch_out_t exp_out;
    int         exp_reqs;
    logic       m_flush;
    logic       done;
    seed = 32'h7cff;
    fetch_ready_i = 1'b0;
    redirect_i = '0;
    cur_pc = `FETCH_PC_INIT;

    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = fill_word(`FETCH_PC_INIT + 32'(i * 4));
    end
    prog[3] = 32'h0000_a083;
    prog[5] = 32'h0000_0463;
    prog[6] = `FETCH_INST_FENCE_I;
    prog[7] = 32'h0000_006f;

    // pc, spec, redirect valid, taken, npc, flush
    add_row(32'h00, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h04, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h08, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h0c, 1'b0, 1'b1, 1'b0, 32'h10, 1'b0);
    add_row(32'h10, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h14, 1'b0, 1'b1, 1'b1, 32'h00, 1'b0);
    add_row(32'h00, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h04, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h08, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h0c, 1'b0, 1'b1, 1'b0, 32'h18, 1'b0);
    add_row(32'h18, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h1c, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h00, 1'b1, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h04, 1'b1, 1'b1, 1'b1, 32'h00, 1'b0);
    add_row(32'h08, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h0c, 1'b0, 1'b1, 1'b0, 32'h10, 1'b0);
    add_row(32'h10, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h14, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h00, 1'b1, 1'b1, 1'b1, 32'h20, 1'b1);
    add_row(32'h20, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h24, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);
    add_row(32'h28, 1'b0, 1'b0, 1'b0, 32'h00, 1'b0);

    m_pc = `FETCH_PC_INIT;
    m_hold = 1'b0;
    m_spec = 1'b0;
    m_spec_target = '0;
    m_pred_v = 1'b0;
    m_pred_t = '0;
    for (int i = 0; i < 4; i++) begin
      m_line_v[i] = 1'b0;
      m_line_tag[i] = '0;
    end

    // look right after the falling edge that releases reset
    wait (rst === 1'b0);
    #1;
    if (fetch_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0 || flush_o !== 1'b0) begin
      $display("outputs are not idle right after reset at %0t", $time);
      stop_with_failure();
    end

    for (int r = 0; r < NUM_STEPS; r++) begin
      row = steps[r];
      if (row.pc !== m_pc || row.spec !== m_spec) begin
        $display("step %0d of the table disagrees with the reference model", r);
        stop_with_failure();
      end
      cur_pc = m_pc;
      row_reqs = 0;
      exp_reqs = line_resident(m_pc) ? 0 : 2;
      exp_out.pc = m_pc;
      exp_out.inst = prog_word(m_pc);
      exp_out.spec = m_spec;
      done = 1'b0;
      while (!done) begin
        @(negedge clk);
        redirect_i = '0;
        fetch_ready_i = ($random(seed) & 3) != 0;
        #1;
        watch_cycle(1'b0);
        if (fetch_valid_o && fetch_ready_i) begin
          check_fetch("fetch_o", fetch_o, exp_out);
          if (row_reqs != exp_reqs) begin
            $display("mismatch at %0t: memory requests for pc %h got %0d, expected %0d",
                     $time, m_pc, row_reqs, exp_reqs);
            stop_with_failure();
          end
          done = 1'b1;
        end
      end

      // step the model over the accepted instruction
      m_line_v[m_pc[4:3]] = 1'b1;
      m_line_tag[m_pc[4:3]] = m_pc[31:5];
      if (exp_out.inst == `FETCH_INST_FENCE_I) begin
        for (int i = 0; i < 4; i++) m_line_v[i] = 1'b0;
      end
      case (classify(exp_out.inst))
        CLS_CTRL: begin
          if (m_pred_v && !m_spec) begin
            m_pc = m_pred_t;
            m_spec = 1'b1;
            m_spec_target = m_pred_t;
          end else begin
            m_hold = 1'b1;
          end
        end
        CLS_LOAD: m_hold = 1'b1;
        default: m_pc = m_pc + 32'd4;
      endcase

      if (row.redirect.valid) begin
        m_flush = 1'b0;
        if (m_spec) begin
          m_spec = 1'b0;
          if (row.redirect.npc != m_spec_target) begin
            m_flush = 1'b1;
            m_pc = row.redirect.npc;
            m_hold = 1'b0;
          end
        end else if (m_hold) begin
          m_pc = row.redirect.npc;
          m_hold = 1'b0;
        end
        if (row.redirect.taken) begin
          m_pred_v = 1'b1;
          m_pred_t = row.redirect.npc;
        end
        if (m_flush !== row.flush) begin
          $display("flush column of step %0d disagrees with the reference model", r);
          stop_with_failure();
        end
        @(negedge clk);
        fetch_ready_i = 1'b0;
        redirect_i = row.redirect;
        #1;
        watch_cycle(row.flush);
      end
    end

    @(negedge clk);
    redirect_i = '0;
    fetch_ready_i = 1'b0;
    #1;
    check_flush(flush_o, 1'b0);

    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  output fetch_pkg::mem_req_t   mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i,
  input  fetch_pkg::redirect_t  redirect_i,
  output fetch_pkg::fetch_out_t fetch_o,
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  output logic                  flush_o
);
  import fetch_pkg::*;

  fetch_addr_u            lookup_addr;
  logic                   inval;
  logic                   hit;
  logic [`FETCH_XLEN-1:0] hit_inst;
  inst_class_e            cls;
  logic                   pred_valid;
  logic [`FETCH_XLEN-1:0] pred_target;

  icache u_icache (
    .clk             (clk),
    .rst             (rst),
    .addr_i          (lookup_addr),
    .inval_i         (inval),
    .hit_o           (hit),
    .inst_o          (hit_inst),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i)
  );

  // the predictor trains on the same redirect that releases fetch
  branch_predictor u_branch_predictor (
    .clk           (clk),
    .rst           (rst),
    .cls_i         (cls),
    .redirect_i    (redirect_i),
    .pred_valid_o  (pred_valid),
    .pred_target_o (pred_target)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .hit_i         (hit),
    .inst_i        (hit_inst),
    .pred_valid_i  (pred_valid),
    .pred_target_i (pred_target),
    .redirect_i    (redirect_i),
    .addr_o        (lookup_addr),
    .inval_o       (inval),
    .cls_o         (cls),
    .fetch_o       (fetch_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .flush_o       (flush_o)
  );

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   hit_i,
  input  logic [`FETCH_XLEN-1:0] inst_i,
  input  logic                   pred_valid_i,
  input  logic [`FETCH_XLEN-1:0] pred_target_i,
  input  fetch_pkg::redirect_t   redirect_i,
  output fetch_pkg::fetch_addr_u addr_o,
  output logic                   inval_o,
  output fetch_pkg::inst_class_e cls_o,
  output fetch_pkg::fetch_out_t  fetch_o,
  output logic                   fetch_valid_o,
  input  logic                   fetch_ready_i,
  output logic                   flush_o
);
  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] INST_BYTES = 4;

  fetch_addr_u            pc_q;
  logic                   hold_q;
  logic                   spec_q;
  logic [`FETCH_XLEN-1:0] pred_q;
  logic                   stall_q;
  logic                   spec_shown_q;

  logic [6:0]             opcode;
  logic                   accept;
  logic                   take_pred;

  // ====================
  // classification
  // ====================

  assign opcode = inst_i[6:0];

  always_comb begin
    case (opcode)
      `FETCH_OP_JAL,
      `FETCH_OP_JALR,
      `FETCH_OP_BRANCH,
      `FETCH_OP_SYSTEM: cls_o = CLS_CTRL;
      `FETCH_OP_LOAD:   cls_o = CLS_LOAD;
      default:          cls_o = CLS_SEQ;
    endcase
  end

  // ====================
  // handshake
  // ====================

  // a wrong guess is resolved in the cycle the redirect shows up
  assign flush_o = redirect_i.valid && spec_q && (redirect_i.npc != pred_q);

  assign fetch_valid_o = hit_i && !hold_q && !flush_o;
  assign accept = fetch_valid_o && fetch_ready_i;
  assign take_pred = accept && (cls_o == CLS_CTRL) && pred_valid_i && !spec_q;
  assign inval_o = accept && (inst_i == `FETCH_INST_FENCE_I);
  assign addr_o = pc_q;

  // a stalled word keeps the spec bit it was first shown with,
  // even if a matching redirect clears spec meanwhile
  always_comb begin
    fetch_o.pc = pc_q.raw;
    fetch_o.inst = inst_i;
    fetch_o.spec = stall_q ? spec_shown_q : spec_q;
  end

  // ====================
  // pc and speculation
  // ====================

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q.raw <= `FETCH_PC_INIT;
      hold_q <= 1'b0;
      spec_q <= 1'b0;
      stall_q <= 1'b0;
    end else begin
      stall_q <= fetch_valid_o && !fetch_ready_i;
      if (accept) begin
        case (cls_o)
          CLS_CTRL: begin
            if (take_pred) begin
              pc_q.raw <= pred_target_i;
              spec_q <= 1'b1;
            end else begin
              hold_q <= 1'b1;
            end
          end
          CLS_LOAD: begin
            hold_q <= 1'b1;
          end
          default: begin
            pc_q.raw <= pc_q.raw + INST_BYTES;
          end
        endcase
      end
      // the oldest open prediction is resolved first, then a held instruction
      if (redirect_i.valid) begin
        if (spec_q) begin
          spec_q <= 1'b0;
          if (flush_o) begin
            pc_q.raw <= redirect_i.npc;
            hold_q <= 1'b0;
          end
        end else if (hold_q) begin
          pc_q.raw <= redirect_i.npc;
          hold_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_pred) begin
      pred_q <= pred_target_i;
    end
    spec_shown_q <= fetch_o.spec;
  end

  a_flush_resolves: assert property (@(posedge clk) disable iff (rst)
    flush_o |=> $past(spec_q) && !spec_q && (pc_q.raw == $past(redirect_i.npc)));

endmodule

`default_nettype wire

// ==== design/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module branch_predictor (
  input  logic                    clk,
  input  logic                    rst,
  input  fetch_pkg::inst_class_e  cls_i,
  input  fetch_pkg::redirect_t    redirect_i,
  output logic                    pred_valid_o,
  output logic [`FETCH_XLEN-1:0]  pred_target_o
);
  import fetch_pkg::*;

  logic                   btb_valid_q;
  logic [`FETCH_XLEN-1:0] btb_target_q;
  logic                   train;

  // only a taken redirect carries a useful target
  assign train = redirect_i.valid && redirect_i.taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid_q <= 1'b0;
    end else if (train) begin
      btb_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (train) begin
      btb_target_q <= redirect_i.npc;
    end
  end

  // sequential words and loads never see a guess
  assign pred_valid_o = btb_valid_q && (cls_i == CLS_CTRL);
  assign pred_target_o = btb_target_q;

  // a stored target has to be a word address the cache can fetch
  a_train_aligned: assert property (@(posedge clk) disable iff (rst)
    train |-> (redirect_i.npc[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== design/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module icache (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_addr_u addr_i,
  input  logic                  inval_i,
  output logic                  hit_o,
  output logic [`FETCH_XLEN-1:0] inst_o,
  output fetch_pkg::mem_req_t   mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i
);
  import fetch_pkg::*;

  localparam int unsigned LINES = 2 ** `FETCH_IDX_W;
  localparam int unsigned WORDS = 2 ** `FETCH_OFS_W;

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_REQ0  = 3'd1;
  localparam logic [2:0] ST_WAIT0 = 3'd2;
  localparam logic [2:0] ST_REQ1  = 3'd3;
  localparam logic [2:0] ST_WAIT1 = 3'd4;

  logic [2:0]             state_q;
  logic [LINES-1:0]       valid_q;
  logic [`FETCH_TAG_W-1:0] tag_q [LINES];
  logic [`FETCH_XLEN-1:0] data_q [LINES][WORDS];

  fetch_addr_u            miss_q;
  fetch_addr_u            req_addr;
  logic [`FETCH_OFS_W-1:0] word_sel;
  logic                   odd_half;
  logic                   rsp_take;

  // ====================
  // lookup
  // ====================

  // lines are only read while no refill is running
  assign hit_o = (state_q == ST_IDLE) && valid_q[addr_i.f.idx]
                 && (tag_q[addr_i.f.idx] == addr_i.f.tag);
  assign inst_o = data_q[addr_i.f.idx][addr_i.f.ofs];

  // ====================
  // refill
  // ====================

  assign odd_half = (state_q == ST_REQ1) || (state_q == ST_WAIT1);
  assign word_sel = `FETCH_OFS_W'(odd_half);
  assign rsp_take = mem_rsp_i.valid && ((state_q == ST_WAIT0) || (state_q == ST_WAIT1));

  always_comb begin
    req_addr = miss_q;
    req_addr.f.ofs = word_sel;
    req_addr.f.byte_sel = 2'b00;
  end

  assign mem_req_o.addr = req_addr.raw;
  assign mem_req_valid_o = (state_q == ST_REQ0) || (state_q == ST_REQ1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!hit_o) begin
            state_q <= ST_REQ0;
          end
        end
        ST_REQ0: begin
          if (mem_req_ready_i) begin
            state_q <= ST_WAIT0;
          end
        end
        ST_WAIT0: begin
          if (mem_rsp_i.valid) begin
            state_q <= ST_REQ1;
          end
        end
        ST_REQ1: begin
          if (mem_req_ready_i) begin
            state_q <= ST_WAIT1;
          end
        end
        ST_WAIT1: begin
          if (mem_rsp_i.valid) begin
            valid_q[miss_q.f.idx] <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
      // fence.i is accepted on a hit, so no refill is in flight here
      if (inval_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && !hit_o) begin
      miss_q <= addr_i;
    end
    if (rsp_take) begin
      data_q[miss_q.f.idx][word_sel] <= mem_rsp_i.data;
    end
    if (rsp_take && (state_q == ST_WAIT1)) begin
      tag_q[miss_q.f.idx] <= miss_q.f.tag;
    end
  end

  // ====================
  // checks
  // ====================

  a_rsp_only_waiting: assert property (@(posedge clk) disable iff (rst)
    mem_rsp_i.valid |-> ((state_q == ST_WAIT0) || (state_q == ST_WAIT1)));

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

  // ====================
  // fetch address
  // ====================

  typedef struct packed {
    logic [`FETCH_TAG_W-1:0] tag;
    logic [`FETCH_IDX_W-1:0] idx;
    logic [`FETCH_OFS_W-1:0] ofs;
    logic [1:0]              byte_sel;
  } fetch_addr_fields_t;

  // the same word seen as a plain address or split up for the cache lookup
  typedef union packed {
    logic [`FETCH_XLEN-1:0] raw;
    fetch_addr_fields_t     f;
  } fetch_addr_u;

  // ====================
  // memory bus
  // ====================

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] data;
  } mem_rsp_t;

  // ====================
  // execute and decode side
  // ====================

  // taken means control flow changed, otherwise the held instruction just retired
  typedef struct packed {
    logic                   valid;
    logic                   taken;
    logic [`FETCH_XLEN-1:0] npc;
  } redirect_t;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] inst;
    logic                   spec;
  } fetch_out_t;

  typedef enum logic [1:0] {
    CLS_SEQ  = 2'd0,
    CLS_CTRL = 2'd1,
    CLS_LOAD = 2'd2
  } inst_class_e;

endpackage

`default_nettype wire

// ==== include/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ====================
// widths
// ====================

`define FETCH_XLEN 32

// ====================
// cache geometry
// ====================

// four lines of two words each
`define FETCH_IDX_W 2
`define FETCH_OFS_W 1
`define FETCH_TAG_W (`FETCH_XLEN - `FETCH_IDX_W - `FETCH_OFS_W - 2)

// ====================
// reset pc and opcodes
// ====================

`define FETCH_PC_INIT 32'h8000_0000

`define FETCH_OP_JAL    7'b110_1111
`define FETCH_OP_JALR   7'b110_0111
`define FETCH_OP_BRANCH 7'b110_0011
`define FETCH_OP_LOAD   7'b000_0011
`define FETCH_OP_SYSTEM 7'b111_0011

// fence.i with all other fields zero
`define FETCH_INST_FENCE_I 32'h0000_100f

`endif
